//--- dehaze_pkg.sv
// Assumes 8-bit channels, Q0.16 fractions and a 3x3 window with the centre at index 4
package dehaze_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int chan_w     = 8;
    localparam int pix_w      = 3 * chan_w;
    localparam int inv_w      = 16;
    localparam int win_pixels = 9;

    // ======================================================================
    // Fixed-point constants
    // ======================================================================
    // Filter weights 1-2-1 in both directions sum to 16
    localparam int mean_shift  = 4;
    // omega = 15/16 applied as x - (x >> 4)
    localparam int omega_shift = 4;
    // Smallest transmission top byte used for 1/t, about 0.1
    localparam int t_floor     = 26;
    // Reciprocal of t in Q4.8
    localparam int recip_w     = 12;

    // Pipeline latencies in clock cycles
    localparam int te_latency = 3;
    localparam int sr_latency = 3;

    // One pixel word, red in the top byte
    // ch[2] is red, ch[1] green and ch[0] blue
    typedef union packed {
        struct packed {
            logic [chan_w-1:0] r;
            logic [chan_w-1:0] g;
            logic [chan_w-1:0] b;
        } rgb;
        logic [2:0][chan_w-1:0] ch;
    } pixel_t;

    // Entry k holds 65536 / max(k, t_floor), rounded down
    function automatic logic [2**chan_w-1:0][recip_w-1:0] build_recip_table();
        logic [2**chan_w-1:0][recip_w-1:0] tbl;
        int unsigned den;
        int unsigned num;
        num = 32'd1 << inv_w;
        for (int k = 0; k < 2**chan_w; k++) begin
            den = (k > t_floor) ? k : t_floor;
            tbl[k] = recip_w'(num / den);
        end
        return tbl;
    endfunction

endpackage

//--- transmission_estimator.sv
// No stall input; window pixel 0 sits in the top bits and the product saturates to all ones
`timescale 1ns/1ps

module transmission_estimator (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    input  logic [dehaze_pkg::win_pixels*dehaze_pkg::pix_w-1:0] window,
    input  logic [dehaze_pkg::inv_w-1:0]      inv_atm_r,
    input  logic [dehaze_pkg::inv_w-1:0]      inv_atm_g,
    input  logic [dehaze_pkg::inv_w-1:0]      inv_atm_b,
    output logic [dehaze_pkg::inv_w-1:0]      trans,
    output logic                              trans_valid
);

    localparam int chan_w = dehaze_pkg::chan_w;
    localparam int inv_w  = dehaze_pkg::inv_w;
    localparam int win_n  = dehaze_pkg::win_pixels;
    localparam int sum_w  = chan_w + dehaze_pkg::mean_shift;
    localparam int prod_w = chan_w + inv_w;

    // Weight exponent of window position i, centre row and column double
    function automatic int weight_shift(input int i);
        int row_mid;
        int col_mid;
        row_mid = ((i / 3) == 1) ? 1 : 0;
        col_mid = ((i % 3) == 1) ? 1 : 0;
        return row_mid + col_mid;
    endfunction

    dehaze_pkg::pixel_t win_pix [win_n];

    logic [2:0][sum_w-1:0]  wsum;
    logic [2:0][chan_w-1:0] mean;

    logic [2:0][chan_w-1:0] mean_q;
    logic [2:0][inv_w-1:0]  inv_q;
    logic                   v1;

    logic [1:0]             sel;
    logic [chan_w-1:0]      min_q;
    logic [inv_w-1:0]       scaled_q;
    logic                   v2;

    logic [prod_w-1:0]      prod;
    logic [inv_w-1:0]       dark;

    // Row-major window, pixel 0 in the most significant slot
    for (genvar i = 0; i < win_n; i++) begin : g_unpack
        assign win_pix[i] = window[(win_n-1-i)*dehaze_pkg::pix_w +: dehaze_pkg::pix_w];
    end

    // ======================================================================
    // Stage 1: weighted mean per channel
    // ======================================================================
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            wsum[c] = '0;
            for (int i = 0; i < win_n; i++) begin
                wsum[c] = wsum[c] + (sum_w'(win_pix[i].ch[c]) << weight_shift(i));
            end
            mean[c] = chan_w'(wsum[c] >> dehaze_pkg::mean_shift);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mean_q <= '0;
            inv_q  <= '0;
            v1     <= 1'b0;
        end else begin
            mean_q <= mean;
            inv_q  <= {inv_atm_r, inv_atm_g, inv_atm_b};
            v1     <= in_valid;
        end
    end

    // ======================================================================
    // Stage 2: darkest channel and its omega-scaled inverse light
    // ======================================================================
    // Ties go to red first, then green
    always_comb begin
        if (mean_q[2] <= mean_q[1] && mean_q[2] <= mean_q[0]) begin
            sel = 2'd2;
        end else if (mean_q[1] <= mean_q[0]) begin
            sel = 2'd1;
        end else begin
            sel = 2'd0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            min_q    <= '0;
            scaled_q <= '0;
            v2       <= 1'b0;
        end else begin
            min_q    <= mean_q[sel];
            scaled_q <= inv_q[sel] - (inv_q[sel] >> dehaze_pkg::omega_shift);
            v2       <= v1;
        end
    end

    // ======================================================================
    // Stage 3: t = 1 - omega * min / A
    // ======================================================================
    assign prod = min_q * scaled_q;
    // Anything at or above 1.0 saturates
    assign dark = (|prod[prod_w-1:inv_w]) ? {inv_w{1'b1}} : prod[inv_w-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trans       <= '0;
            trans_valid <= 1'b0;
        end else begin
            trans       <= {inv_w{1'b1}} - dark;
            trans_valid <= v2;
        end
    end

endmodule

//--- pixel_delay_line.sv
// Fixed depth of te_latency stages with no enable; data shifts every cycle
`timescale 1ns/1ps

module pixel_delay_line (
    input  logic                          clk,
    input  logic                          rst,
    input  dehaze_pkg::pixel_t            center,
    input  logic [dehaze_pkg::chan_w-1:0] atm_r,
    input  logic [dehaze_pkg::chan_w-1:0] atm_g,
    input  logic [dehaze_pkg::chan_w-1:0] atm_b,
    output dehaze_pkg::pixel_t            center_d,
    output logic [dehaze_pkg::chan_w-1:0] atm_d_r,
    output logic [dehaze_pkg::chan_w-1:0] atm_d_g,
    output logic [dehaze_pkg::chan_w-1:0] atm_d_b
);

    localparam int depth = dehaze_pkg::te_latency;

    dehaze_pkg::pixel_t                   center_sr [depth];
    logic [2:0][dehaze_pkg::chan_w-1:0]   atm_sr    [depth];

    // Matches the transmission estimator so each pixel meets its own t
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                center_sr[i] <= '0;
                atm_sr[i]    <= '0;
            end
        end else begin
            center_sr[0] <= center;
            atm_sr[0]    <= {atm_r, atm_g, atm_b};
            for (int i = 1; i < depth; i++) begin
                center_sr[i] <= center_sr[i-1];
                atm_sr[i]    <= atm_sr[i-1];
            end
        end
    end

    assign center_d = center_sr[depth-1];
    assign atm_d_r  = atm_sr[depth-1][2];
    assign atm_d_g  = atm_sr[depth-1][1];
    assign atm_d_b  = atm_sr[depth-1][0];

endmodule

//--- scene_recovery.sv
// Reciprocal uses only the top byte of t, floored at t_floor; done holds until reset
`timescale 1ns/1ps

module scene_recovery #(
    parameter int frame_pixels = 262144
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trans_valid,
    input  logic [dehaze_pkg::inv_w-1:0]  trans,
    input  dehaze_pkg::pixel_t            center_d,
    input  logic [dehaze_pkg::chan_w-1:0] atm_d_r,
    input  logic [dehaze_pkg::chan_w-1:0] atm_d_g,
    input  logic [dehaze_pkg::chan_w-1:0] atm_d_b,
    output logic [dehaze_pkg::chan_w-1:0] j_r,
    output logic [dehaze_pkg::chan_w-1:0] j_g,
    output logic [dehaze_pkg::chan_w-1:0] j_b,
    output logic                          out_valid,
    output logic                          done
);

    localparam int chan_w  = dehaze_pkg::chan_w;
    localparam int recip_w = dehaze_pkg::recip_w;
    localparam int mult_w  = chan_w + recip_w;
    localparam int cnt_w   = $clog2(frame_pixels + 1);

    // 1/t in Q4.8, indexed by the top byte of t
    localparam logic [2**chan_w-1:0][recip_w-1:0] recip_rom =
        dehaze_pkg::build_recip_table();

    logic [2:0][chan_w-1:0] pix;
    logic [2:0][chan_w-1:0] atm;

    logic [recip_w-1:0]     recip_q;
    logic [2:0][chan_w-1:0] dist_q;
    logic [2:0]             add_q;
    logic [2:0][chan_w-1:0] atm1_q;
    logic                   v1;

    logic [2:0][mult_w-1:0] scaled_full;
    logic [2:0][chan_w-1:0] scaled_q;
    logic [2:0]             add2_q;
    logic [2:0][chan_w-1:0] atm2_q;
    logic                   v2;

    logic [2:0][chan_w:0]   sum;
    logic [2:0][chan_w-1:0] j_next;
    logic [2:0][chan_w-1:0] j_q;

    logic [cnt_w-1:0]       out_cnt;

    assign pix = {center_d.rgb.r, center_d.rgb.g, center_d.rgb.b};
    assign atm = {atm_d_r, atm_d_g, atm_d_b};

    // ======================================================================
    // Stage 1: reciprocal lookup and |I - A| per channel
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            recip_q <= '0;
            dist_q  <= '0;
            add_q   <= '0;
            atm1_q  <= '0;
            v1      <= 1'b0;
        end else begin
            recip_q <= recip_rom[trans[dehaze_pkg::inv_w-1 -: chan_w]];
            for (int c = 0; c < 3; c++) begin
                add_q[c]  <= (pix[c] >= atm[c]);
                dist_q[c] <= (pix[c] >= atm[c]) ? pix[c] - atm[c] : atm[c] - pix[c];
            end
            atm1_q  <= atm;
            v1      <= trans_valid;
        end
    end

    // ======================================================================
    // Stage 2: distance scaled by 1/t
    // ======================================================================
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            scaled_full[c] = dist_q[c] * recip_q;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scaled_q <= '0;
            add2_q   <= '0;
            atm2_q   <= '0;
            v2       <= 1'b0;
        end else begin
            for (int c = 0; c < 3; c++) begin
                // Drop the 8 fraction bits and saturate to 255
                if (|scaled_full[c][mult_w-1:2*chan_w]) begin
                    scaled_q[c] <= '1;
                end else begin
                    scaled_q[c] <= scaled_full[c][2*chan_w-1:chan_w];
                end
            end
            add2_q <= add_q;
            atm2_q <= atm1_q;
            v2     <= v1;
        end
    end

    // ======================================================================
    // Stage 3: J = A +/- scaled distance, clamped to 0..255
    // ======================================================================
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            if (add2_q[c]) begin
                sum[c]    = {1'b0, atm2_q[c]} + {1'b0, scaled_q[c]};
                j_next[c] = sum[c][chan_w] ? {chan_w{1'b1}} : sum[c][chan_w-1:0];
            end else begin
                sum[c]    = {1'b0, atm2_q[c]} - {1'b0, scaled_q[c]};
                // Borrow out means the result went below zero
                j_next[c] = sum[c][chan_w] ? '0 : sum[c][chan_w-1:0];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            j_q       <= '0;
            out_valid <= 1'b0;
        end else begin
            j_q       <= j_next;
            out_valid <= v2;
        end
    end

    assign j_r = j_q[2];
    assign j_g = j_q[1];
    assign j_b = j_q[0];

    // ======================================================================
    // Frame counter on output pixels
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_cnt <= '0;
            done    <= 1'b0;
        end else if (out_valid && !done) begin
            out_cnt <= out_cnt + 1'b1;
            if (out_cnt == cnt_w'(frame_pixels - 1)) begin
                done <= 1'b1;
            end
        end
    end

endmodule

//--- dehaze_top.sv
// Six-cycle fixed latency with no back-pressure; all inputs sampled with in_valid
`timescale 1ns/1ps

module dehaze_top #(
    parameter int frame_pixels = 262144
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [dehaze_pkg::win_pixels*dehaze_pkg::pix_w-1:0] window,
    input  logic [dehaze_pkg::chan_w-1:0] atm_r,
    input  logic [dehaze_pkg::chan_w-1:0] atm_g,
    input  logic [dehaze_pkg::chan_w-1:0] atm_b,
    input  logic [dehaze_pkg::inv_w-1:0]  inv_atm_r,
    input  logic [dehaze_pkg::inv_w-1:0]  inv_atm_g,
    input  logic [dehaze_pkg::inv_w-1:0]  inv_atm_b,
    output logic [dehaze_pkg::chan_w-1:0] j_r,
    output logic [dehaze_pkg::chan_w-1:0] j_g,
    output logic [dehaze_pkg::chan_w-1:0] j_b,
    output logic                          out_valid,
    output logic                          done
);

    // Centre of the row-major window, counted from pixel 0 at the top bits
    localparam int center_idx = dehaze_pkg::win_pixels / 2;
    localparam int center_lsb = (dehaze_pkg::win_pixels - 1 - center_idx) * dehaze_pkg::pix_w;

    dehaze_pkg::pixel_t                center;
    dehaze_pkg::pixel_t                center_d;
    logic [dehaze_pkg::chan_w-1:0]     atm_d_r;
    logic [dehaze_pkg::chan_w-1:0]     atm_d_g;
    logic [dehaze_pkg::chan_w-1:0]     atm_d_b;
    logic [dehaze_pkg::inv_w-1:0]      trans;
    logic                              trans_valid;

    assign center = window[center_lsb +: dehaze_pkg::pix_w];

    transmission_estimator i_te (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .window      (window),
        .inv_atm_r   (inv_atm_r),
        .inv_atm_g   (inv_atm_g),
        .inv_atm_b   (inv_atm_b),
        .trans       (trans),
        .trans_valid (trans_valid)
    );

    pixel_delay_line i_dly (
        .clk      (clk),
        .rst      (rst),
        .center   (center),
        .atm_r    (atm_r),
        .atm_g    (atm_g),
        .atm_b    (atm_b),
        .center_d (center_d),
        .atm_d_r  (atm_d_r),
        .atm_d_g  (atm_d_g),
        .atm_d_b  (atm_d_b)
    );

    scene_recovery #(
        .frame_pixels (frame_pixels)
    ) i_sr (
        .clk         (clk),
        .rst         (rst),
        .trans_valid (trans_valid),
        .trans       (trans),
        .center_d    (center_d),
        .atm_d_r     (atm_d_r),
        .atm_d_g     (atm_d_g),
        .atm_d_b     (atm_d_b),
        .j_r         (j_r),
        .j_g         (j_g),
        .j_b         (j_b),
        .out_valid   (out_valid),
        .done        (done)
    );

endmodule

//--- dehaze_checker.sv
// Bound to dehaze_top; assumes the fixed six-cycle latency and that in_valid is never X after reset
`timescale 1ns/1ps

module dehaze_checker (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic out_valid,
    input logic done
);

    // Failure count, read by the testbench at the end of the run
    int fail_cnt = 0;

    // ======================================================================
    // Valid timing
    // ======================================================================
    // Each attempt starts out of reset and looks six edges ahead
    a_latency : assert property (@(posedge clk) disable iff (rst)
        ##6 (out_valid == $past(in_valid, 6)))
        else begin
            fail_cnt++;
            $error("out_valid does not match in_valid from six cycles earlier");
        end

    a_reset_quiet : assert property (@(posedge clk) rst |-> !out_valid)
        else begin
            fail_cnt++;
            $error("out_valid is high while reset is asserted");
        end

    // done is sticky until the next reset
    a_done_sticky : assert property (@(posedge clk) disable iff (rst) done |=> done)
        else begin
            fail_cnt++;
            $error("done fell while reset was low");
        end

endmodule

bind dehaze_top dehaze_checker i_chk (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .done      (done)
);

//--- dehaze_monitor.sv
// Expects each accepted pixel six cycles later in order; test names hold up to 16 characters
`timescale 1ns/1ps

module dehaze_monitor #(
    parameter int frame_pixels = 12
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  logic [215:0] window,
    input  logic [7:0]   atm_r,
    input  logic [7:0]   atm_g,
    input  logic [7:0]   atm_b,
    input  logic [15:0]  inv_atm_r,
    input  logic [15:0]  inv_atm_g,
    input  logic [15:0]  inv_atm_b,
    input  logic [127:0] test_name,
    input  logic [7:0]   j_r,
    input  logic [7:0]   j_g,
    input  logic [7:0]   j_b,
    input  logic         out_valid,
    input  logic         done,
    output int           pass_cnt,
    output int           err_cnt,
    output int           pending
);

    localparam int latency = 6;

    logic [23:0]  exp_q  [$];
    logic [127:0] name_q [$];
    int           cyc_q  [$];
    int           cycle;
    int           out_seen;
    logic         done_reported;

    // Channel c of a pixel, 2 is red and 0 is blue
    function automatic int chan_of(input logic [23:0] p, input int c);
        return int'(p[c*8 +: 8]);
    endfunction

    // ======================================================================
    // Reference model of the dehazing rules
    // ======================================================================
    function automatic logic [23:0] predict(input logic [215:0] w, input logic [23:0] a,
                                            input logic [47:0] inv);
        int          weights [9];
        int          mean [3];
        int          sel;
        int          inv_sel;
        int          prod;
        int          t_top;
        int          recip;
        int          p;
        int          q;
        int          step;
        int          j;
        logic [23:0] centre;
        logic [23:0] res;
        weights = '{1, 2, 1, 2, 4, 2, 1, 2, 1};
        for (int c = 0; c < 3; c++) begin
            mean[c] = 0;
            for (int i = 0; i < 9; i++) begin
                mean[c] += weights[i] * chan_of(w[(8-i)*24 +: 24], c);
            end
            mean[c] = mean[c] / 16;
        end
        // Darkest channel, red before green before blue on ties
        if (mean[2] <= mean[1] && mean[2] <= mean[0]) begin
            sel = 2;
        end else if (mean[1] <= mean[0]) begin
            sel = 1;
        end else begin
            sel = 0;
        end
        inv_sel = int'(inv[sel*16 +: 16]);
        prod    = mean[sel] * (inv_sel - inv_sel / 16);
        if (prod > 65535) begin
            prod = 65535;
        end
        t_top  = (65535 - prod) / 256;
        recip  = 65536 / ((t_top < 26) ? 26 : t_top);
        centre = w[4*24 +: 24];
        for (int c = 0; c < 3; c++) begin
            p    = chan_of(centre, c);
            q    = chan_of(a, c);
            step = ((p >= q) ? p - q : q - p) * recip / 256;
            if (step > 255) begin
                step = 255;
            end
            j = (p >= q) ? q + step : q - step;
            j = (j > 255) ? 255 : ((j < 0) ? 0 : j);
            res[c*8 +: 8] = 8'(j);
        end
        return res;
    endfunction

    initial begin
        pass_cnt      = 0;
        err_cnt       = 0;
        pending       = 0;
        done_reported = 1'b0;
    end

    always @(posedge clk) begin : watch
        logic [23:0]  exp_pix;
        logic [23:0]  got;
        logic [127:0] name;
        int           in_cyc;
        if (rst) begin
            exp_q.delete();
            name_q.delete();
            cyc_q.delete();
            cycle    = 0;
            out_seen = 0;
            pending  = 0;
        end else begin
            cycle++;
            // done reflects the outputs seen on earlier edges
            if (done !== (out_seen >= frame_pixels)) begin
                err_cnt++;
                $display("CHECK FAILED done after %0d outputs: expected %0b, actual %0b",
                         out_seen, out_seen >= frame_pixels, done);
            end else if (done === 1'b1 && !done_reported) begin
                done_reported = 1'b1;
                pass_cnt++;
                $display("ok    done rose after %0d outputs", out_seen);
            end
            if (in_valid === 1'b1) begin
                exp_q.push_back(predict(window, {atm_r, atm_g, atm_b},
                                        {inv_atm_r, inv_atm_g, inv_atm_b}));
                name_q.push_back(test_name);
                cyc_q.push_back(cycle);
            end
            if (out_valid === 1'b1) begin
                out_seen++;
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("Output appeared at cycle %0d with no pixel in flight", cycle);
                end else begin
                    exp_pix = exp_q.pop_front();
                    name    = name_q.pop_front();
                    in_cyc  = cyc_q.pop_front();
                    got     = {j_r, j_g, j_b};
                    if (cycle - in_cyc != latency) begin
                        err_cnt++;
                        $display("Pixel %0s came out %0d cycles after input instead of %0d",
                                 name, cycle - in_cyc, latency);
                    end else if (got !== exp_pix) begin
                        err_cnt++;
                        $display("CHECK FAILED %0s: expected %h, actual %h", name, exp_pix, got);
                    end else begin
                        pass_cnt++;
                        $display("ok    %0s  pixel %h", name, got);
                    end
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

//--- tb_dehaze.sv
// Runs one 12-pixel frame from a fixed table and one random pixel after it; reads no files
`timescale 1ns/1ps

module tb_dehaze;

    localparam int  frame_size  = 12;
    localparam int  n_entries   = 12;
    localparam time clk_period  = 40ns;
    localparam int  win_w       = dehaze_pkg::win_pixels * dehaze_pkg::pix_w;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic [win_w-1:0] window;
    logic [7:0]       atm_r;
    logic [7:0]       atm_g;
    logic [7:0]       atm_b;
    logic [15:0]      inv_atm_r;
    logic [15:0]      inv_atm_g;
    logic [15:0]      inv_atm_b;
    logic [127:0]     test_name;
    logic [7:0]       j_r;
    logic [7:0]       j_g;
    logic [7:0]       j_b;
    logic             out_valid;
    logic             done;
    int               pass_cnt;
    int               err_cnt;
    int               pending;

    // Stimulus table, one named pixel per row plus idle cycles after it
    logic [win_w-1:0] tbl_win  [n_entries];
    logic [23:0]      tbl_atm  [n_entries];
    logic [127:0]     tbl_name [n_entries];
    int               tbl_idle [n_entries];
    int               n_added;
    int               idle_total;
    int               wd_cycles;
    logic             table_ready;

    always #20 clk = ~clk;

    dehaze_top #(.frame_pixels(frame_size)) i_dut (
        .clk (clk), .rst (rst), .in_valid (in_valid), .window (window),
        .atm_r (atm_r), .atm_g (atm_g), .atm_b (atm_b),
        .inv_atm_r (inv_atm_r), .inv_atm_g (inv_atm_g), .inv_atm_b (inv_atm_b),
        .j_r (j_r), .j_g (j_g), .j_b (j_b), .out_valid (out_valid), .done (done)
    );

    dehaze_monitor #(.frame_pixels(frame_size)) i_mon (
        .clk (clk), .rst (rst), .in_valid (in_valid), .window (window),
        .atm_r (atm_r), .atm_g (atm_g), .atm_b (atm_b),
        .inv_atm_r (inv_atm_r), .inv_atm_g (inv_atm_g), .inv_atm_b (inv_atm_b),
        .test_name (test_name), .j_r (j_r), .j_g (j_g), .j_b (j_b),
        .out_valid (out_valid), .done (done),
        .pass_cnt (pass_cnt), .err_cnt (err_cnt), .pending (pending)
    );

    // Q0.16 reciprocal of the atmospheric light, capped at all ones
    function automatic logic [15:0] inv_of(input logic [7:0] a);
        int q;
        q = (a == 8'd0) ? 65536 : 65536 / a;
        return (q > 65535) ? 16'hffff : 16'(q);
    endfunction

    // Eight border pixels equal, centre at index 4
    function automatic logic [win_w-1:0] make_window(input logic [23:0] edge_pix,
                                                     input logic [23:0] centre_pix);
        logic [win_w-1:0] w;
        for (int i = 0; i < 9; i++) begin
            w[(8-i)*24 +: 24] = (i == 4) ? centre_pix : edge_pix;
        end
        return w;
    endfunction

    task automatic add_entry(input logic [127:0] name, input logic [23:0] edge_pix,
                             input logic [23:0] centre_pix, input logic [23:0] atm,
                             input int idle);
        tbl_win[n_added]  = make_window(edge_pix, centre_pix);
        tbl_atm[n_added]  = atm;
        tbl_name[n_added] = name;
        tbl_idle[n_added] = idle;
        n_added++;
        idle_total += idle;
    endtask

    task automatic apply_pixel(input logic [win_w-1:0] w, input logic [23:0] a,
                               input logic [127:0] name);
        in_valid  = 1'b1;
        window    = w;
        atm_r     = a[23:16];
        atm_g     = a[15:8];
        atm_b     = a[7:0];
        inv_atm_r = inv_of(a[23:16]);
        inv_atm_g = inv_of(a[15:8]);
        inv_atm_b = inv_of(a[7:0]);
        test_name = name;
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        logic [win_w-1:0] rnd_win;
        logic [23:0]      rnd_atm;
        int               seed_val;
        seed_val    = $urandom(32'h889);
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        window      = '0;
        atm_r       = '0;
        atm_g       = '0;
        atm_b       = '0;
        inv_atm_r   = '0;
        inv_atm_g   = '0;
        inv_atm_b   = '0;
        test_name   = '0;
        n_added     = 0;
        idle_total  = 0;
        table_ready = 1'b0;
        add_entry("uniform_a",     24'hc8b4a0, 24'hc8b4a0, 24'hc8b4a0, 0);
        add_entry("uniform_b",     24'h5a6e82, 24'h5a6e82, 24'h5a6e82, 2);
        add_entry("dark_red",      24'h3080c0, 24'h4070a0, 24'he0d0c0, 0);
        add_entry("dark_blue",     24'ha09030, 24'h908020, 24'hf0e0d0, 1);
        add_entry("tie_red_green", 24'h5050a0, 24'h6060b0, 24'hc0d0e0, 0);
        add_entry("sub_clamp",     24'hf0f0f0, 24'h000000, 24'hf8f8f8, 0);
        add_entry("add_clamp",     24'hd0d0d0, 24'hffffff, 24'hc0c0c0, 2);
        add_entry("near_opaque",   24'hb0a090, 24'hb8a898, 24'hb4a494, 0);
        add_entry("mixed_signs",   24'h406080, 24'h20a060, 24'h8090a0, 0);
        add_entry("low_light",     24'h101010, 24'h080808, 24'h404040, 1);
        add_entry("bright_sky",    24'he0e8f0, 24'hf0f0f0, 24'hf0f4f8, 0);
        add_entry("gray_mid",      24'h808080, 24'h707070, 24'h909090, 3);
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
        for (int e = 0; e < n_entries; e++) begin
            @(posedge clk);
            #2 apply_pixel(tbl_win[e], tbl_atm[e], tbl_name[e]);
            for (int k = 0; k < tbl_idle[e]; k++) begin
                @(posedge clk);
                #2 in_valid = 1'b0;
            end
        end
        @(posedge clk);
        #2 in_valid = 1'b0;
        wait (done === 1'b1);

        // One random pixel after the frame has completed
        for (int i = 0; i < 9; i++) begin
            rnd_win[(8-i)*24 +: 24] = 24'($urandom);
        end
        rnd_atm = 24'($urandom) | 24'h404040;
        @(posedge clk);
        #2 apply_pixel(rnd_win, rnd_atm, "random_tail");
        @(posedge clk);
        #2 in_valid = 1'b0;
        wait (pending == 0);
        repeat (3) @(posedge clk);

        $display("Summary: %0d passed, %0d failed, %0d assertion failures",
                 pass_cnt, err_cnt, i_dut.i_chk.fail_cnt);
        if (err_cnt == 0 && i_dut.i_chk.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized from the table length and its idle gaps
    initial begin
        wait (table_ready === 1'b1);
        wd_cycles = n_entries + idle_total + 20;
        #(wd_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d clock periods", wd_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- src.f
dehaze_pkg.sv
transmission_estimator.sv
pixel_delay_line.sv
scene_recovery.sv
dehaze_top.sv
dehaze_checker.sv
dehaze_monitor.sv
tb_dehaze.sv
